// ==== design/sysctl_defines.svh ====
`ifndef SYSCTL_DEFINES_SVH
`define SYSCTL_DEFINES_SVH

// Refresh timer runs 0..REFRESH_LAST, one step per E fall
`define REFRESH_LAST 10
`define REFRESH_BITS 4

// Long timer counts refresh groups
`define LTIMER_BITS 12

`define QOS_WIDTH 4 // QoS countdown width

// Register map
`define QOS_SETTINGS_ADDR 8'h00
`define QOS_STATUS_ADDR 8'h04 // qosEn above the QoS count

`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== design/sysCtlPkg.sv ====
`default_nettype none

package sysCtlPkg;

	// Peripheral chip selects, gated by bus activity
	typedef struct packed {
		logic iack;  // Interrupt acknowledge
		logic via;
		logic iwm;   // Floppy controller
		logic scc;   // Serial controller
		logic scsi;
		logic sndWr; // Sound buffer write
	} qosSelect_t;

	// Slow bits follow qosSelect_t order
	typedef struct packed {
		logic slowIack;
		logic slowVia;
		logic slowIwm;
		logic slowScc;
		logic slowScsi;
		logic slowSndWr;
		logic slowClockGate;      // Sound writes may gate the CPU clock
		logic [3:0] slowInterval; // Refresh groups to hold QoS
	} qosSettings_t;

	typedef struct packed {
		logic req;
		logic urg; // Refresh overdue soon
	} refreshStatus_t;

	// One-cycle pulses plus C8M health
	typedef struct packed {
		logic eFall;
		logic c8mFall;
		logic c8mAlive;
	} clkEvents_t;

	typedef struct packed {
		logic [7:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [7:0] araddr;
		logic arvalid;
		logic rready;
	} axiLiteReq_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiLiteResp_t;

endpackage

`default_nettype wire

// ==== design/clockEdgeDetect.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockEdgeDetect import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire logic e,   // E clock, asynchronous
	input wire logic c8m, // 8 MHz bus clock, asynchronous
	output clkEvents_t events
);

	logic [1:0] eHist;   // Bit 0 is the newest sample
	logic [3:0] c8mHist; // Longer history for the stall check

	always_ff @(posedge CLK) begin
		if (rst) begin
			eHist <= '0;
			c8mHist <= '0;
			events <= '0;
		end else begin
			eHist <= {eHist[0], e};
			c8mHist <= {c8mHist[2:0], c8m};
			events.eFall <= eHist[1] & ~eHist[0];
			events.c8mFall <= c8mHist[1] & ~c8mHist[0];
			// Four equal samples means C8M has stopped
			if (c8mHist == 4'b0000 || c8mHist == 4'b1111) begin
				events.c8mAlive <= 1'b0;
			end else if (c8mHist[1:0] == 2'b01) begin
				events.c8mAlive <= 1'b1; // Fresh rising sample
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/intervalTimers.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sysctl_defines.svh"

module intervalTimers import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire clkEvents_t events,
	output refreshStatus_t refresh,
	output logic timerTick, // End of each refresh group
	output logic longTick   // Long timer wrap
);

	logic [`REFRESH_BITS-1:0] refTimer;
	logic [`LTIMER_BITS-1:0] lTimer;
	logic refLast;
	logic lLast;

	assign refLast = refTimer == `REFRESH_BITS'(`REFRESH_LAST);
	assign lLast = &lTimer;

	// Refresh timer, one state per E period
	always_ff @(posedge CLK) begin
		if (rst) begin
			refTimer <= '0;
			refresh <= '0;
			timerTick <= 1'b0;
		end else begin
			timerTick <= events.eFall & refLast;
			if (events.eFall) begin
				refTimer <= refLast ? '0 : refTimer + 1'b1;
				refresh.req <= !refLast; // Quiet only after the last state
				refresh.urg <= refTimer == `REFRESH_BITS'(`REFRESH_LAST - 2) ||
					refTimer == `REFRESH_BITS'(`REFRESH_LAST - 1);
			end
		end
	end

	// Long timer for the startup sequence
	always_ff @(posedge CLK) begin
		if (rst) begin
			lTimer <= '0;
			longTick <= 1'b0;
		end else begin
			longTick <= timerTick & lLast;
			if (timerTick) lTimer <= lTimer + 1'b1; // Wraps naturally
		end
	end

endmodule

`default_nettype wire

// ==== design/qosThrottle.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sysctl_defines.svh"

module qosThrottle import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire logic inReset, // Startup holds the throttle idle
	input wire logic bact,
	input wire logic nAs,
	input wire logic asRf,    // Active-low refresh-cycle strobe
	input wire qosSelect_t sel,
	input wire qosSettings_t settings,
	input wire clkEvents_t events,
	input wire logic timerTick,
	output logic qosEn,
	output logic mcke,
	output logic [`QOS_WIDTH-1:0] qosCount
);

	qosSelect_t selR; // Selects seen during bus activity
	logic slowHit;
	logic otherSel;
	logic gateEn;

	// Any select whose slow bit is set
	assign slowHit = (selR.iack & settings.slowIack) | (selR.via & settings.slowVia) |
		(selR.iwm & settings.slowIwm) | (selR.scc & settings.slowScc) |
		(selR.scsi & settings.slowScsi) | (selR.sndWr & settings.slowSndWr);
	assign otherSel = selR.iack | selR.via | selR.iwm | selR.scc | selR.scsi;

	always_ff @(posedge CLK) begin
		if (rst) begin
			selR <= '0;
			qosCount <= '0;
			gateEn <= 1'b0;
			qosEn <= 1'b0;
			mcke <= 1'b1;
		end else begin
			selR <= bact ? sel : '0;
			if (inReset) begin
				qosCount <= '0;
			end else if (slowHit) begin
				qosCount <= `QOS_WIDTH'(settings.slowInterval); // Reload the hold time
			end else if (timerTick && qosCount != '0) begin
				qosCount <= qosCount - 1'b1; // One step per refresh group
			end
			// Clock gate armed only by sound writes
			if (inReset || otherSel) gateEn <= 1'b0;
			else if (selR.sndWr && settings.slowClockGate) gateEn <= 1'b1;
			if (inReset) qosEn <= 1'b0;
			else if (!bact) qosEn <= qosCount != '0; // Change only between bus cycles
			if (!nAs) mcke <= 1'b1; // Never stall a running CPU cycle
			else mcke <= !(qosEn && gateEn && !asRf && !events.c8mFall);
		end
	end

endmodule

`default_nettype wire

// ==== design/qosRegs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sysctl_defines.svh"

module qosRegs import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire axiLiteReq_t axiIn,
	output axiLiteResp_t axiOut,
	output qosSettings_t settings,
	input wire logic qosEn,
	input wire logic [`QOS_WIDTH-1:0] qosCount
);

	logic wrAccept;
	logic rdAccept;
	logic wrHit;      // Write to the settings register
	logic bvalidR;
	logic rvalidR;
	logic [1:0] brespR;
	logic [1:0] rrespR;
	logic [31:0] rdataR;

	// Accept only while no response of the same kind is pending
	assign wrAccept = axiIn.awvalid & axiIn.wvalid & ~bvalidR;
	assign rdAccept = axiIn.arvalid & ~rvalidR;
	assign wrHit = axiIn.awaddr == `QOS_SETTINGS_ADDR;

	always_ff @(posedge CLK) begin
		if (rst) begin
			settings <= '0;
			bvalidR <= 1'b0;
		end else if (wrAccept) begin
			bvalidR <= 1'b1;
			if (wrHit && axiIn.wstrb[0]) settings[7:0] <= axiIn.wdata[7:0];
			if (wrHit && axiIn.wstrb[1]) settings[10:8] <= axiIn.wdata[10:8];
		end else if (axiIn.bready) begin
			bvalidR <= 1'b0;
		end
	end

	// Status address is read-only, so only the settings address is OKAY
	always_ff @(posedge CLK) begin
		if (wrAccept) brespR <= wrHit ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
	end

	always_ff @(posedge CLK) begin
		if (rst) rvalidR <= 1'b0;
		else if (rdAccept) rvalidR <= 1'b1;
		else if (axiIn.rready) rvalidR <= 1'b0;
	end

	// Read data held until the response is taken
	always_ff @(posedge CLK) begin
		if (rdAccept) begin
			case (axiIn.araddr)
				`QOS_SETTINGS_ADDR: begin
					rdataR <= 32'(settings);
					rrespR <= `AXI_RESP_OKAY;
				end
				`QOS_STATUS_ADDR: begin
					rdataR <= 32'({qosEn, qosCount});
					rrespR <= `AXI_RESP_OKAY;
				end
				default: begin
					rdataR <= '0;
					rrespR <= `AXI_RESP_SLVERR;
				end
			endcase
		end
	end

	always_comb begin
		axiOut.awready = wrAccept; // Address and data taken together
		axiOut.wready = wrAccept;
		axiOut.bresp = brespR;
		axiOut.bvalid = bvalidR;
		axiOut.arready = rdAccept;
		axiOut.rdata = rdataR;
		axiOut.rresp = rrespR;
		axiOut.rvalid = rvalidR;
	end

endmodule

`default_nettype wire

// ==== design/startupControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module startupControl import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire logic nResIn, // Reset button
	input wire logic nIpl2,  // NMI button
	input wire clkEvents_t events,
	input wire logic longTick,
	output logic nPor,
	output logic inReset,
	output logic nResOut,
	output logic nBrIob,     // Bus request to the host, active low
	output logic aoutOe      // PDS address and control drive
);

	typedef enum logic [1:0] {stHold0, stHold1, stNmiWin, stRun} startState_t;

	startState_t state;
	logic [1:0] nResSync; // Button synchronizer
	logic [1:0] nIplSync;

	assign inReset = !nPor || !nResSync[1];

	always_ff @(posedge CLK) begin
		if (rst) begin
			nPor <= 1'b0;
			nResSync <= '0;
			nIplSync <= 2'b11;
			state <= stHold0;
			nResOut <= 1'b0;
			nBrIob <= 1'b0;
			aoutOe <= 1'b0;
		end else begin
			nPor <= events.c8mAlive;
			nResSync <= {nResSync[0], nResIn};
			nIplSync <= {nIplSync[0], nIpl2};
			// Lost C8M restarts the whole sequence
			if (!nPor) state <= stHold0;
			else if (state == stHold0 && longTick) state <= stHold1;
			else if (state == stHold1 && longTick) state <= stNmiWin;
			else if (state == stNmiWin && longTick && nIplSync[1]) state <= stRun;
			case (state)
				stHold0, stHold1: begin
					aoutOe <= 1'b0; // Tristate PDS bus
					nResOut <= 1'b0;
					nBrIob <= 1'b0; // Request the host bus
				end
				stNmiWin: begin
					aoutOe <= 1'b0;
					nResOut <= 1'b0;
					if (!nIplSync[1]) nBrIob <= 1'b1; // NMI gives the bus back
				end
				default: begin
					aoutOe <= !nBrIob;
					if (longTick) nResOut <= 1'b1; // Release reset one period later
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/sysCtlTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sysctl_defines.svh"

module sysCtlTop import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire logic e,
	input wire logic c8m,
	input wire logic nResIn,
	input wire logic nIpl2,
	input wire logic nAs,
	input wire logic asRf,
	input wire logic bact,
	input wire qosSelect_t sel,    // Raw peripheral selects
	input wire axiLiteReq_t axiIn,
	output axiLiteResp_t axiOut,
	output refreshStatus_t refresh,
	output logic nPor,
	output logic nResOut,
	output logic nBrIob,
	output logic aoutOe,
	output logic qosEn,
	output logic mcke
);

	clkEvents_t events;
	qosSettings_t settings;
	logic timerTick;
	logic longTick;
	logic inReset;
	logic [`QOS_WIDTH-1:0] qosCount; // Throttle count for the status register

	clockEdgeDetect edge_i (.*);
	intervalTimers timers_i (.*);
	qosRegs regs_i (.*);
	qosThrottle throttle_i (.*);
	startupControl startup_i (.*);

endmodule

`default_nettype wire

// ==== test/sysCtl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysCtlProperties import sysCtlPkg::*; (
	input wire logic CLK,
	input wire logic rst,
	input wire logic nAs,
	input wire logic qosEn,
	input wire logic mcke,
	input wire axiLiteReq_t axiIn,
	input wire axiLiteResp_t axiOut
);

	int failCount = 0;

	// Running bus cycle or idle throttle keeps the CPU clocked
	mckeHeld: assert property (@(posedge CLK) disable iff (rst) (!nAs || !qosEn) |=> mcke)
		else begin
			$error("Error %0t: mcke is %b, expected 1", $time, mcke);
			failCount++;
		end

	bHold: assert property (@(posedge CLK) disable iff (rst)
		axiOut.bvalid && !axiIn.bready |=> axiOut.bvalid && $stable(axiOut.bresp))
		else begin
			$error("Error %0t: axiOut.bvalid is %b, expected 1 with bresp held", $time,
				axiOut.bvalid);
			failCount++;
		end

	rHold: assert property (@(posedge CLK) disable iff (rst)
		axiOut.rvalid && !axiIn.rready |=> axiOut.rvalid && $stable(axiOut.rdata))
		else begin
			$error("Error %0t: axiOut.rvalid is %b, expected 1 with rdata held", $time,
				axiOut.rvalid);
			failCount++;
		end

endmodule

bind sysCtlTop sysCtlProperties props_i (.*);

`default_nettype wire

// ==== test/sysCtlTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sysctl_defines.svh"

module sysCtlTb import sysCtlPkg::*; ();

	localparam int groupLen = `REFRESH_LAST + 1;       // E falls per refresh group
	localparam int longLen = groupLen << `LTIMER_BITS; // E falls per long-timer period

	logic CLK, rst, e, c8m, nResIn, nIpl2, nAs, asRf, bact;
	qosSelect_t sel;
	axiLiteReq_t axiIn;
	axiLiteResp_t axiOut;
	refreshStatus_t refresh;
	logic nPor, nResOut, nBrIob, aoutOe, qosEn, mcke;
	logic c8mRun; // Low stops C8M
	int phase;
	int eCount;   // E falls driven since reset
	int errCount;
	int errAtStart;
	int testCount;
	int badTests;

	sysCtlTop dut_i (.*);

	always #4 CLK = !CLK;

	// E toggles every 5 cycles and C8M every 2
	always @(posedge CLK) begin
		#1;
		if (!rst) begin
			phase++;
			if (c8mRun && phase % 2 == 0) c8m = !c8m;
			if (phase % 5 == 0) begin
				if (e) begin
					if (eCount > 0) checkRefresh(); // Value left by the previous fall
					eCount++;
				end
				e = !e;
			end
		end
	end

	function automatic int totalErrors();
		return errCount + dut_i.props_i.failCount;
	endfunction

	task automatic expectValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errCount++;
		end
	endtask

	task automatic expectTrue(input logic ok, input string what);
		assert (ok) else begin
			$display("Failure at %0t: %s", $time, what);
			errCount++;
		end
	endtask

	task automatic abortRun(input string what);
		$display("Timeout at %0t waiting for %s", $time, what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic reportTest(input string name);
		testCount++;
		if (totalErrors() != errAtStart) badTests++;
		$display("%-14s %s", name, totalErrors() == errAtStart ? "ok" : "errors");
		errAtStart = totalErrors();
	endtask

	// Timer state ended by the last fall decides req and urg
	task automatic checkRefresh();
		int s;
		s = (eCount - 1) % groupLen;
		expectValue("refresh.req", refresh.req, s != `REFRESH_LAST);
		expectValue("refresh.urg", refresh.urg, s == `REFRESH_LAST - 2 || s == `REFRESH_LAST - 1);
	endtask

	task automatic waitLevel(ref logic sig, input logic level, input int limit, input string what);
		int t;
		t = 0;
		while (sig !== level) begin
			@(negedge CLK);
			t++;
			if (t > limit) abortRun(what);
		end
	endtask

	task automatic waitFalls(input int modulus, input int target, input int maxFalls,
			input string what);
		int t;
		t = 0;
		while (eCount % modulus != target) begin
			@(negedge CLK);
			t++;
			if (t > maxFalls * 10 + 20) abortRun(what);
		end
	endtask

	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data, input int hold,
			output logic [1:0] resp);
		int t;
		@(posedge CLK);
		#1;
		axiIn.awaddr = addr;
		axiIn.wdata = data;
		axiIn.wstrb = 4'hf;
		axiIn.awvalid = 1'b1;
		axiIn.wvalid = 1'b1;
		t = 0;
		do begin
			@(negedge CLK);
			t++;
			if (t > 20) abortRun("awready");
		end while (!axiOut.awready);
		expectValue("axiOut.wready", axiOut.wready, 1'b1); // Pulses with awready
		@(posedge CLK);
		#1;
		axiIn.awvalid = 1'b0;
		axiIn.wvalid = 1'b0;
		repeat (hold + 1) begin // bready low the whole time
			expectTrue(axiOut.bvalid, "bvalid dropped while bready was low");
			@(negedge CLK);
		end
		resp = axiOut.bresp;
		@(posedge CLK);
		#1 axiIn.bready = 1'b1;
		@(posedge CLK);
		#1 axiIn.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] addr, input int hold, output logic [31:0] data,
			output logic [1:0] resp);
		int t;
		@(posedge CLK);
		#1;
		axiIn.araddr = addr;
		axiIn.arvalid = 1'b1;
		t = 0;
		do begin
			@(negedge CLK);
			t++;
			if (t > 20) abortRun("arready");
		end while (!axiOut.arready);
		@(posedge CLK);
		#1 axiIn.arvalid = 1'b0;
		repeat (hold + 1) begin
			expectTrue(axiOut.rvalid, "rvalid dropped while rready was low");
			@(negedge CLK);
		end
		data = axiOut.rdata;
		resp = axiOut.rresp;
		@(posedge CLK);
		#1 axiIn.rready = 1'b1;
		@(posedge CLK);
		#1 axiIn.rready = 1'b0;
	endtask

	task automatic registerTest();
		logic [1:0] resp;
		logic [31:0] data;
		logic [31:0] value;
		value = $urandom & 32'h7ff; // Eleven settings bits
		axiWrite(`QOS_SETTINGS_ADDR, value, 3, resp);
		expectValue("bresp", resp, `AXI_RESP_OKAY);
		axiRead(`QOS_SETTINGS_ADDR, 2, data, resp);
		expectValue("rdata", data, value);
		expectValue("rresp", resp, `AXI_RESP_OKAY);
		axiWrite(`QOS_STATUS_ADDR, ~value, 0, resp); // Read-only
		expectValue("bresp", resp, `AXI_RESP_SLVERR);
		axiWrite(8'h08, ~value, 1, resp);
		expectValue("bresp", resp, `AXI_RESP_SLVERR);
		axiRead(8'h08, 1, data, resp);
		expectValue("rresp", resp, `AXI_RESP_SLVERR);
		axiRead(`QOS_SETTINGS_ADDR, 0, data, resp);
		expectValue("rdata", data, value); // Rejected writes left it alone
	endtask

	// One select taken during bus activity in the middle of a refresh group
	task automatic pulseSelect(input qosSelect_t s);
		waitFalls(groupLen, 5, groupLen, "middle of a refresh group");
		@(posedge CLK);
		#1;
		bact = 1'b1;
		sel = s;
		@(posedge CLK);
		#1 sel = '0;
		@(posedge CLK);
		#1;
		expectValue("qosEn", qosEn, 0); // Held while bact is high
		bact = 1'b0;
	endtask

	task automatic qosTest();
		logic [1:0] resp;
		logic [5:0] slowMask;
		int src;
		int other;
		int interval;
		int e0;
		src = $urandom % 6;
		other = (src + 1) % 6;
		interval = 1 + $urandom % 3;
		slowMask = 6'($urandom);
		slowMask[src] = 1'b1;
		slowMask[other] = 1'b0;
		axiWrite(`QOS_SETTINGS_ADDR, {slowMask, 1'b0, 4'(interval)}, 0, resp);
		pulseSelect(6'(1 << other)); // Fast source
		repeat (10) @(negedge CLK);
		expectValue("qosEn", qosEn, 0);
		pulseSelect(6'(1 << src));
		waitLevel(qosEn, 1'b1, 10, "qosEn after a slow select");
		e0 = eCount;
		waitLevel(qosEn, 1'b0, (interval + 1) * groupLen * 10, "qosEn to clear");
		expectValue("refresh groups with qosEn", eCount / groupLen - e0 / groupLen, interval);
	endtask

	task automatic clockTest();
		logic [1:0] resp;
		logic seenLow;
		qosSelect_t s;
		s = '0;
		s.sndWr = 1'b1;
		axiWrite(`QOS_SETTINGS_ADDR, {6'b000001, 1'b1, 4'd2}, 0, resp); // Gate on sound writes
		pulseSelect(s);
		waitLevel(qosEn, 1'b1, 10, "qosEn after a sound write");
		seenLow = 1'b0;
		@(posedge CLK);
		#1 asRf = 1'b0;
		repeat (8) begin
			@(negedge CLK);
			if (!mcke) seenLow = 1'b1;
		end
		expectTrue(seenLow, "mcke stayed high during asRf with the gate armed");
		@(posedge CLK);
		#1 nAs = 1'b0; // Strobe override
		repeat (4) @(posedge CLK);
		#1;
		nAs = 1'b1;
		asRf = 1'b1;
		waitLevel(qosEn, 1'b0, 3 * groupLen * 10, "qosEn to clear");
	endtask

	task automatic powerOnTest();
		int m;
		@(posedge CLK);
		#1 c8mRun = 1'b0;
		waitLevel(nPor, 1'b0, 20, "nPor after C8M stops");
		waitLevel(nResOut, 1'b0, 10, "nResOut after C8M stops");
		if (eCount % longLen == 0) waitFalls(longLen, 1, longLen, "clear of a period boundary");
		@(posedge CLK);
		#1 c8mRun = 1'b1;
		waitLevel(nPor, 1'b1, 20, "nPor after C8M restarts");
		m = eCount / longLen; // Period holding the restart
		waitFalls(1 << 30, (m + 2) * longLen + longLen / 2, 3 * longLen, "third startup period");
		@(posedge CLK);
		#1 nIpl2 = 1'b0; // NMI hands the host bus back
		repeat (20) @(posedge CLK);
		#1 nIpl2 = 1'b1;
		waitLevel(nResOut, 1'b1, 2 * longLen * 10, "nResOut release after restart");
		expectValue("E falls at nResOut release", eCount, (m + 4) * longLen);
		repeat (4) @(negedge CLK);
		expectValue("nBrIob", nBrIob, 1);
		expectValue("aoutOe", aoutOe, 0);
	endtask

	initial begin
		void'($urandom(32'h7b2c));
		{CLK, e, c8m, bact} = '0;
		{rst, nResIn, nIpl2, nAs, asRf, c8mRun} = '1;
		sel = '0;
		axiIn = '0;
		{phase, eCount, errCount, errAtStart, testCount, badTests} = '0;
		repeat (2) @(posedge CLK);
		#1 rst = 1'b0;
		waitLevel(nPor, 1'b1, 50, "nPor after reset");
		waitFalls(1 << 30, 3 * groupLen, 3 * groupLen, "three refresh groups");
		reportTest("refresh");
		registerTest();
		reportTest("registers");
		qosTest();
		reportTest("qos enable");
		clockTest();
		reportTest("clock enable");
		waitLevel(nResOut, 1'b1, 4 * longLen * 10 + 100, "nResOut release");
		expectValue("E falls at nResOut release", eCount, 4 * longLen);
		repeat (2) @(negedge CLK);
		expectValue("nBrIob", nBrIob, 0);
		expectValue("aoutOe", aoutOe, 1);
		reportTest("startup");
		powerOnTest();
		reportTest("power-on reset");
		$display("Tests %0d, tests with errors %0d, failed checks %0d",
			testCount, badTests, totalErrors());
		if (totalErrors() == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/sysCtlPkg.sv
design/clockEdgeDetect.sv
design/intervalTimers.sv
design/qosThrottle.sv
design/qosRegs.sv
design/startupControl.sv
design/sysCtlTop.sv
test/sysCtl_properties.sv
test/sysCtlTb.sv
